// ==== sim.f ====
verilog/icache_pkg.sv
verilog/icache_ctrl_if.sv
verilog/icache_control.sv
verilog/icache_datapath.sv
verilog/icache.sv
test/pmem_model.sv
test/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert --top-module icache_tb -f sim.f -o icache_sim > sim.log 2>&1 &&
./obj_dir/icache_sim >> sim.log 2>&1 ||
echo "*** FAILED ***" >> sim.log
cat sim.log
if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	exit 1
fi
exit 0

// ==== test/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

	import icache_pkg::*;

	localparam int NUM_SETS = 16;
	localparam int SET_BITS = $clog2(NUM_SETS);
	localparam int RANDOM_READS = 250;
	localparam int MAX_CYCLES_PER_READ = 12;
	localparam int TIMEOUT_CYCLES = 300 * MAX_CYCLES_PER_READ + 2400;
	localparam int TAG_A = 1;
	localparam int TAG_B = 2;
	localparam int TAG_C = 3;

	logic  clk = 1'b0;
	logic  reset;
	logic  mem_read;
	addr_t mem_address;
	logic  mem_resp;
	word_t mem_rdata;
	logic  pmem_read;
	addr_t pmem_address;
	logic  pmem_resp;
	line_t pmem_rdata;
	int    line_reads;

	logic [31:0] lfsr_state = 32'hc682_c3bc;
	addr_t       pending [$];
	int          errors = 0;
	int          checked = 0;
	int          last_reads = 0;
	int          cycle_count = 0;
	addr_t       req_addr;
	word_t       exp_word;
	bit          exp_miss;

	// reference cache state
	bit          ref_valid [2][NUM_SETS];
	logic [26:0] ref_line [2][NUM_SETS];
	bit          ref_lru [NUM_SETS];

	icache #(.NUM_SETS(NUM_SETS)) UUT (
		.clk          (clk),
		.reset        (reset),
		.mem_read     (mem_read),
		.mem_address  (mem_address),
		.mem_resp     (mem_resp),
		.mem_rdata    (mem_rdata),
		.pmem_read    (pmem_read),
		.pmem_address (pmem_address),
		.pmem_resp    (pmem_resp),
		.pmem_rdata   (pmem_rdata)
	);

	pmem_model u_pmem (
		.clk          (clk),
		.reset        (reset),
		.pmem_read    (pmem_read),
		.pmem_address (pmem_address),
		.pmem_resp    (pmem_resp),
		.pmem_rdata   (pmem_rdata),
		.line_reads   (line_reads)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int random_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
		return value;
	endfunction

	function automatic addr_t make_addr(input int tag, input int idx, input int word);
		return addr_t'((tag << (SET_BITS + 5)) | (idx << 5) | (word << 2));
	endfunction

	// memory holds the address xor a constant, rotated left by 7
	function automatic word_t expected_word(input addr_t a);
		word_t x;
		x = a ^ 32'h5a3c_96e1;
		return {x[24:0], x[31:25]};
	endfunction

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// fills go to the least recently used way and the used way becomes most recent
	function automatic word_t expect_read(input addr_t addr, output bit miss);
		int          idx;
		int          way;
		logic [26:0] line_no;
		idx = int'(addr[5 +: SET_BITS]);
		line_no = addr[31:5];
		miss = 1'b1;
		way = 0;
		for (int w = 0; w < 2; w++) begin
			if (ref_valid[w][idx] && ref_line[w][idx] == line_no) begin
				miss = 1'b0;
				way = w;
			end
		end
		if (miss) begin
			way = int'(ref_lru[idx]);
			ref_valid[way][idx] = 1'b1;
			ref_line[way][idx] = line_no;
		end
		ref_lru[idx] = (way == 0);
		return expected_word(addr);
	endfunction

	task automatic read_word(input addr_t addr);
		@(negedge clk);
		mem_read = 1'b1;
		mem_address = addr;
		pending.push_back(addr);
		do begin
			@(negedge clk);
		end while (!mem_resp);
		mem_read = 1'b0;
	endtask

	task automatic check_quiet();
		if (mem_resp !== 1'b0) begin
			$display("Mismatch at %0t: mem_resp = %b, expected 0", $time, mem_resp);
			errors++;
		end
		if (pmem_read !== 1'b0) begin
			$display("Mismatch at %0t: pmem_read = %b, expected 0", $time, pmem_read);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// comparison
	////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset && mem_resp) begin
			if (pending.size() == 0) begin
				$display("mem_resp at %0t with no request outstanding", $time);
				errors++;
			end else begin
				req_addr = pending.pop_front();
				exp_word = expect_read(req_addr, exp_miss);
				checked++;
				if (mem_rdata !== exp_word) begin
					$display("Mismatch at %0t: mem_rdata = %h, expected %h (address %h)",
						$time, mem_rdata, exp_word, req_addr);
					errors++;
				end
				if (line_reads - last_reads != (exp_miss ? 1 : 0)) begin
					$display("Mismatch at %0t: line_reads delta = %0d, expected %0d (address %h)",
						$time, line_reads - last_reads, exp_miss ? 1 : 0, req_addr);
					errors++;
				end
				last_reads = line_reads;
			end
		end
		if (!reset && pmem_read && pending.size() != 0) begin
			if (pmem_address !== {pending[0][31:5], 5'b0}) begin
				$display("Mismatch at %0t: pmem_address = %h, expected %h",
					$time, pmem_address, {pending[0][31:5], 5'b0});
				errors++;
			end
		end
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, reads checked %0d, errors %0d",
			cycle_count, checked, errors);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		reset = 1'b1;
		mem_read = 1'b0;
		mem_address = '0;
		for (int w = 0; w < 2; w++) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				ref_valid[w][s] = 1'b0;
				ref_line[w][s] = '0;
				ref_lru[s] = 1'b0;
			end
		end
		repeat (2) begin
			@(negedge clk);
			check_quiet();
		end
		reset = 1'b0;
		@(negedge clk);
		check_quiet();

		// every set starts empty, then hits on another word of each line
		for (int s = 0; s < NUM_SETS; s++) begin
			read_word(make_addr(TAG_A, s, s % 8));
		end
		for (int s = 0; s < NUM_SETS; s++) begin
			read_word(make_addr(TAG_A, s, 7 - s % 8));
		end

		// second way of set 3
		read_word(make_addr(TAG_B, 3, 0));
		for (int k = 0; k < 4; k++) begin
			read_word(make_addr(TAG_A, 3, k));
			read_word(make_addr(TAG_B, 3, k + 4));
		end

		// third tag evicts the older line
		read_word(make_addr(TAG_A, 3, 1));
		read_word(make_addr(TAG_C, 3, 2));
		// kept line still hits, evicted line misses
		read_word(make_addr(TAG_A, 3, 5));
		read_word(make_addr(TAG_B, 3, 3));
		read_word(make_addr(TAG_C, 3, 4));

		// small pool of four tags over four sets
		for (int n = 0; n < RANDOM_READS; n++) begin
			read_word(make_addr(random_bits(2) + 1, random_bits(2), random_bits(3)));
		end

		@(negedge clk);
		$display("reads checked %0d, errors %0d", checked, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== test/pmem_model.sv ====
`timescale 1ns/1ps

module pmem_model #(
	parameter logic [31:0] SEED = 32'hc682_c3bc
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              pmem_read,
	input  icache_pkg::addr_t pmem_address,
	output logic              pmem_resp,
	output icache_pkg::line_t pmem_rdata,
	output int                line_reads
);

	import icache_pkg::*;

	logic [31:0] lfsr = SEED;
	logic        busy;
	int          remaining;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// three bits per request give 1 to 8 cycles
	function automatic int pick_delay();
		int d;
		d = 0;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_next(lfsr);
			d = (d << 1) | int'(lfsr[0]);
		end
		return d + 1;
	endfunction

	function automatic word_t word_at(input addr_t a);
		word_t x;
		x = a ^ 32'h5a3c_96e1;
		return {x[24:0], x[31:25]};
	endfunction

	function automatic line_t line_at(input addr_t base);
		line_t line;
		for (int i = 0; i < 8; i++) begin
			line[i*32 +: 32] = word_at(base + addr_t'(i * 4));
		end
		return line;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			pmem_resp  <= 1'b0;
			pmem_rdata <= '0;
			busy       <= 1'b0;
			remaining  <= 0;
			line_reads <= 0;
		end else begin
			pmem_resp <= 1'b0;
			if (busy) begin
				if (remaining == 1) begin
					pmem_resp  <= 1'b1;
					pmem_rdata <= line_at(pmem_address);
					busy       <= 1'b0;
					line_reads <= line_reads + 1;
				end else begin
					remaining <= remaining - 1;
				end
			end else if (pmem_read && !pmem_resp) begin
				// read is still high in the resp cycle, so no restart there
				busy      <= 1'b1;
				remaining <= pick_delay();
			end
		end
	end

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/1ps

module icache #(
	parameter int unsigned NUM_SETS = 16
) (
	input  logic              clk,
	input  logic              reset,
	// fetch side
	input  logic              mem_read,
	input  icache_pkg::addr_t mem_address,
	output logic              mem_resp,
	output icache_pkg::word_t mem_rdata,
	// physical memory side
	output logic              pmem_read,
	output icache_pkg::addr_t pmem_address,
	input  logic              pmem_resp,
	input  icache_pkg::line_t pmem_rdata
);

	import icache_pkg::*;

	cache_cw_t req_cw;
	cache_cw_t pipe_cw;

	icache_ctrl_if #(.NUM_SETS(NUM_SETS)) ctrl_bus ();

	// incoming request as one control word
	assign req_cw.mem_read = mem_read;
	assign req_cw.address  = mem_address;

	icache_control u_control (
		.clk       (clk),
		.reset     (reset),
		.req_cw    (req_cw),
		.pipe_cw   (pipe_cw),
		.pmem_resp (pmem_resp),
		.pmem_read (pmem_read),
		.mem_resp  (mem_resp),
		.ctl       (ctrl_bus.ctrl)
	);

	icache_datapath #(.NUM_SETS(NUM_SETS)) u_datapath (
		.clk          (clk),
		.reset        (reset),
		.req_cw       (req_cw),
		.pmem_rdata   (pmem_rdata),
		.pipe_cw      (pipe_cw),
		.mem_rdata    (mem_rdata),
		.pmem_address (pmem_address),
		.dp           (ctrl_bus.dp)
	);

endmodule

// ==== verilog/icache_datapath.sv ====
`timescale 1ns/1ps

module icache_datapath #(
	parameter int unsigned NUM_SETS = 16
) (
	input  logic                  clk,
	input  logic                  reset,
	input  icache_pkg::cache_cw_t req_cw,
	input  icache_pkg::line_t     pmem_rdata,
	output icache_pkg::cache_cw_t pipe_cw,
	output icache_pkg::word_t     mem_rdata,
	output icache_pkg::addr_t     pmem_address,
	icache_ctrl_if.dp             dp
);

	import icache_pkg::*;

	localparam int unsigned INDEX_BITS = $clog2(NUM_SETS);
	localparam int unsigned TAG_BITS   = $bits(addr_t) - INDEX_BITS - LINE_OFFSET_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0]   tag_t;

	index_t req_index;
	index_t pipe_index;
	index_t rd_index;
	tag_t   pipe_tag;
	logic [WORD_SEL_BITS-1:0] word_idx;

	// two ways of storage
	line_t data_mem [2][NUM_SETS];
	tag_t  tag_mem [2][NUM_SETS];
	logic [1:0][NUM_SETS-1:0] valid;
	// per set, the way to replace next
	logic [NUM_SETS-1:0] lru;

	line_t      line_q [2];
	tag_t       tag_q [2];
	logic [1:0] valid_q;
	logic [1:0] way_hit;
	line_t      sel_line;

	////////////////////////////////////////
	// request stage
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pipe_cw <= '0;
		end else if (dp.load_pipeline) begin
			pipe_cw <= req_cw;
		end
	end

	assign req_index  = req_cw.address[LINE_OFFSET_BITS +: INDEX_BITS];
	assign pipe_index = pipe_cw.address[LINE_OFFSET_BITS +: INDEX_BITS];
	assign pipe_tag   = pipe_cw.address[$bits(addr_t)-1 -: TAG_BITS];
	assign word_idx   = pipe_cw.address[LINE_OFFSET_BITS-1 -: WORD_SEL_BITS];

	// staged index for the reread after a fill
	assign rd_index = dp.addr_sel ? pipe_index : req_index;

	////////////////////////////////////////
	// arrays
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (dp.fill_way[w]) begin
				data_mem[w][pipe_index] <= pmem_rdata;
				tag_mem[w][pipe_index]  <= pipe_tag;
			end
			if (dp.read_data) begin
				line_q[w] <= data_mem[w][rd_index];
				tag_q[w]  <= tag_mem[w][rd_index];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid   <= '0;
			valid_q <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (dp.fill_way[w]) begin
					valid[w][pipe_index] <= 1'b1;
				end
				if (dp.read_data) begin
					valid_q[w] <= valid[w][rd_index];
				end
			end
		end
	end

	// way 0 hit means way 1 goes next
	always_ff @(posedge clk) begin
		if (reset) begin
			lru <= '0;
		end else if (dp.load_lru) begin
			lru[pipe_index] <= way_hit[0];
		end
	end

	////////////////////////////////////////
	// compare and select
	////////////////////////////////////////

	assign way_hit[0] = valid_q[0] && (tag_q[0] == pipe_tag);
	assign way_hit[1] = valid_q[1] && (tag_q[1] == pipe_tag);
	assign dp.hit     = |way_hit;
	assign dp.lru_way = lru[pipe_index];

	assign sel_line  = way_hit[1] ? line_q[1] : line_q[0];
	assign mem_rdata = sel_line[word_idx * $bits(word_t) +: $bits(word_t)];

	assign pmem_address = {pipe_cw.address[$bits(addr_t)-1:LINE_OFFSET_BITS],
		{LINE_OFFSET_BITS{1'b0}}};

	a_one_way_hit: assert property (@(posedge clk) disable iff (reset)
		!(&way_hit));

	// control never fills two ways from one line
	a_fill_single: assert property (@(posedge clk) disable iff (reset)
		dp.fill_way != 2'b11);

endmodule

// ==== verilog/icache_control.sv ====
`timescale 1ns/1ps

module icache_control (
	input  logic                  clk,
	input  logic                  reset,
	input  icache_pkg::cache_cw_t req_cw,
	input  icache_pkg::cache_cw_t pipe_cw,
	input  logic                  pmem_resp,
	output logic                  pmem_read,
	output logic                  mem_resp,
	icache_ctrl_if.ctrl           ctl
);

	typedef enum logic [2:0] {
		idle,
		hit_detection,
		load,
		write_data,
		hit_after_miss
	} state_t;

	state_t state;
	state_t next_state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb begin
		next_state = state;
		unique case (state)
			idle: begin
				if (req_cw.mem_read) begin
					next_state = hit_detection;
				end
			end
			hit_detection: begin
				next_state = ctl.hit ? idle : load;
			end
			load: begin
				// wait here for as long as memory takes
				if (pmem_resp) begin
					next_state = write_data;
				end
			end
			write_data: begin
				if (pipe_cw.mem_read) begin
					next_state = hit_after_miss;
				end
			end
			hit_after_miss: begin
				next_state = idle;
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

	////////////////////////////////////////
	// state outputs
	////////////////////////////////////////

	always_comb begin
		pmem_read         = 1'b0;
		mem_resp          = 1'b0;
		ctl.read_data     = 1'b0;
		ctl.addr_sel      = 1'b0;
		ctl.load_pipeline = 1'b0;
		ctl.fill_way      = 2'b00;
		ctl.load_lru      = 1'b0;
		unique case (state)
			idle: begin
				ctl.load_pipeline = 1'b1;
				ctl.read_data     = req_cw.mem_read;
			end
			hit_detection: begin
				if (ctl.hit) begin
					mem_resp     = 1'b1;
					ctl.load_lru = 1'b1;
				end else begin
					pmem_read = 1'b1;
				end
			end
			load: begin
				// read held through the resp cycle
				pmem_read = 1'b1;
				if (pmem_resp) begin
					ctl.fill_way = ctl.lru_way ? 2'b10 : 2'b01;
				end
			end
			write_data: begin
				// reread the filled set from the staged address
				ctl.read_data = pipe_cw.mem_read;
				ctl.addr_sel  = 1'b1;
			end
			hit_after_miss: begin
				mem_resp     = 1'b1;
				ctl.load_lru = 1'b1;
			end
			default: begin
			end
		endcase
	end

	a_resp_excl: assert property (@(posedge clk) disable iff (reset)
		!(mem_resp && pmem_read));

	// memory sees a steady request until it answers
	a_pmem_hold: assert property (@(posedge clk) disable iff (reset)
		pmem_read && !pmem_resp |=> pmem_read);

endmodule

// ==== verilog/icache_ctrl_if.sv ====
`timescale 1ns/1ps

interface icache_ctrl_if #(
	parameter int unsigned NUM_SETS = 16
);

	// status from datapath
	logic       hit;
	logic       lru_way;

	// strobes from control
	logic       read_data;
	logic       addr_sel;
	logic       load_pipeline;
	logic [1:0] fill_way;
	logic       load_lru;

	modport ctrl (
		input  hit, lru_way,
		output read_data, addr_sel, load_pipeline, fill_way, load_lru
	);

	modport dp (
		input  read_data, addr_sel, load_pipeline, fill_way, load_lru,
		output hit, lru_way
	);

	// set index is cut straight from the address
	initial begin
		assert (NUM_SETS >= 2 && (NUM_SETS & (NUM_SETS - 1)) == 0)
			else $fatal(1, "icache_ctrl_if: NUM_SETS must be a power of two");
	end

endinterface

// ==== verilog/icache_pkg.sv ====
package icache_pkg;

	////////////////////////////////////////
	// basic widths
	////////////////////////////////////////

	// one instruction word
	typedef logic [31:0] word_t;

	// byte address from fetch
	typedef logic [31:0] addr_t;

	// one line of eight words as returned by physical memory
	typedef logic [255:0] line_t;

	////////////////////////////////////////
	// line geometry
	////////////////////////////////////////

	// byte offset inside a 32 byte line
	localparam int unsigned LINE_OFFSET_BITS = 5;

	// word index inside a line sits just above the byte lane bits
	localparam int unsigned WORD_SEL_BITS = 3;

	////////////////////////////////////////
	// request control word
	////////////////////////////////////////

	// incoming request and its staged copy share this layout
	typedef struct packed {
		logic  mem_read;
		addr_t address;
	} cache_cw_t;

endpackage
